//--- rtl/rv32i_pkg.sv
package rv32i_pkg;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD  = 3'b000; // SUB in OP when funct7[5] is set.
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101; // SRA when funct7[5] is set.
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam int INST_QUEUE_DEPTH = 8;
    localparam int INST_QUEUE_AW    = $clog2(INST_QUEUE_DEPTH);

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS // LUI, second operand goes straight through.
    } alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_word_u;

endpackage

//--- rtl/rv32i_result_if.sv
`timescale 1ns/1ps

interface rv32i_result_if;

    logic        valid;
    logic [4:0]  rd;
    logic [31:0] data;

    modport src (
        output valid,
        output rd,
        output data
    );

    modport dst (
        input valid,
        input rd,
        input data
    );

endinterface

//--- rtl/rv32i_inst_queue.sv
`timescale 1ns/1ps

module rv32i_inst_queue import rv32i_pkg::*; (
    input  logic       CLK,
    input  logic       RST,
    input  logic       push,
    input  inst_word_u push_inst,
    input  logic       pop,
    output inst_word_u head,
    output logic       not_empty
);

    inst_word_u               mem [INST_QUEUE_DEPTH];
    logic [INST_QUEUE_AW:0]   wptr;
    logic [INST_QUEUE_AW:0]   rptr;
    logic                     full;

    // the extra pointer bit tells a full buffer from an empty one.
    assign full = (wptr[INST_QUEUE_AW] != rptr[INST_QUEUE_AW]) &&
                  (wptr[INST_QUEUE_AW-1:0] == rptr[INST_QUEUE_AW-1:0]);
    assign not_empty = (wptr != rptr);
    assign head = mem[rptr[INST_QUEUE_AW-1:0]];

    always_ff @(posedge CLK) begin
        if (RST) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (push) begin
                wptr <= wptr + 1'b1;
            end
            if (pop) begin
                rptr <= rptr + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wptr[INST_QUEUE_AW-1:0]] <= push_inst;
        end
    end

    a_no_overflow: assert property (@(posedge CLK) disable iff (RST)
        !(push && full))
        else $error("instruction queue written while full");

    a_no_underflow: assert property (@(posedge CLK) disable iff (RST)
        !(pop && !not_empty))
        else $error("instruction queue popped while empty");

endmodule

//--- rtl/rv32i_issue.sv
`timescale 1ns/1ps

module rv32i_issue import rv32i_pkg::*; (
    input  logic        CLK,
    input  logic        RST,
    input  inst_word_u  head,
    input  logic        not_empty,
    output logic        pop,
    output logic        issue_valid,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [4:0]  rd_ahead,
    input  logic        a_rvalid,
    input  logic        b_rvalid,
    input  logic [31:0] a_rdata,
    input  logic [31:0] b_rdata,
    output logic        stall,
    output logic        ex_valid,
    output alu_op_t     ex_op,
    output logic [31:0] ex_a,
    output logic [31:0] ex_b,
    output logic [4:0]  ex_rd
);

    logic        dec_ok;
    logic        dec_use_rs1;
    logic        dec_use_rs2;
    alu_op_t     dec_op;
    logic [31:0] dec_imm;

    logic        r_valid;
    logic        r_use_rs1;
    logic        r_use_rs2;
    alu_op_t     r_op;
    logic [31:0] r_imm;
    logic [4:0]  r_rd;

    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt,
                                        input logic is_reg);
        case (f3)
            F3_ADD:  alu_sel = (alt && is_reg) ? ALU_SUB : ALU_ADD; // no SUBI in RV32I.
            F3_SLL:  alu_sel = ALU_SLL;
            F3_SLT:  alu_sel = ALU_SLT;
            F3_SLTU: alu_sel = ALU_SLTU;
            F3_XOR:  alu_sel = ALU_XOR;
            F3_SRL:  alu_sel = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   alu_sel = ALU_OR;
            default: alu_sel = ALU_AND;
        endcase
    endfunction

    always_comb begin
        dec_ok      = 1'b0;
        dec_use_rs1 = 1'b0;
        dec_use_rs2 = 1'b0;
        dec_op      = ALU_ADD;
        dec_imm     = {{20{head.i.imm12[11]}}, head.i.imm12};
        case (head.r.opcode)
            OPC_OP: begin
                dec_ok      = 1'b1;
                dec_use_rs1 = 1'b1;
                dec_use_rs2 = 1'b1;
                dec_op      = alu_sel(head.r.funct3, head.r.funct7[5], 1'b1);
            end
            OPC_OP_IMM: begin
                dec_ok      = 1'b1;
                dec_use_rs1 = 1'b1;
                dec_op      = alu_sel(head.i.funct3, head.i.imm12[10], 1'b0);
            end
            OPC_LUI: begin
                dec_ok  = 1'b1;
                dec_op  = ALU_PASS;
                dec_imm = {head.r.funct7, head.r.rs2, head.r.rs1, head.r.funct3, 12'd0};
            end
            default: begin
                dec_ok = 1'b0; // anything else is popped and thrown away.
            end
        endcase
    end

    assign pop         = not_empty && !stall;
    assign issue_valid = pop && dec_ok;
    // unused sources read x0 so that an immediate field never raises a false hazard.
    assign rs1      = dec_use_rs1 ? head.i.rs1 : 5'd0;
    assign rs2      = dec_use_rs2 ? head.r.rs2 : 5'd0;
    assign rd_ahead = r_valid ? r_rd : 5'd0; // becomes the pending rd once it moves to exec.
    assign stall    = r_valid && (!a_rvalid || !b_rvalid);

    always_ff @(posedge CLK) begin
        if (RST) begin
            r_valid  <= 1'b0;
            ex_valid <= 1'b0;
        end else begin
            if (!stall) begin
                r_valid <= issue_valid;
            end
            ex_valid <= r_valid && !stall;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_valid) begin
            r_use_rs1 <= dec_use_rs1;
            r_use_rs2 <= dec_use_rs2;
            r_op      <= dec_op;
            r_imm     <= dec_imm;
            r_rd      <= head.r.rd;
        end
        if (r_valid && !stall) begin
            ex_op <= r_op;
            ex_a  <= r_use_rs1 ? a_rdata : 32'd0;
            ex_b  <= r_use_rs2 ? b_rdata : r_imm;
            ex_rd <= r_rd;
        end
    end

    // a hazard costs exactly one bubble before the held instruction reaches exec.
    a_stall_bubble: assert property (@(posedge CLK) disable iff (RST)
        stall |=> (!ex_valid && !stall) ##1 ex_valid)
        else $error("stalled instruction did not reach exec after one bubble");

endmodule

//--- rtl/rv32i_reg.sv
`timescale 1ns/1ps

module rv32i_reg (
    input  logic        CLK,
    input  logic        RST,
    input  logic        stall,
    input  logic        issue_valid,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd_ahead,
    output logic        a_rvalid,
    output logic        b_rvalid,
    output logic [31:0] a_rdata,
    output logic [31:0] b_rdata,
    rv32i_result_if.dst exec_res,
    rv32i_result_if.dst cushion_res
);

    logic [31:0] regs [32];
    logic [4:0]  a_addr;
    logic [4:0]  b_addr;
    logic [4:0]  pend_rd;

    always_ff @(posedge CLK) begin
        if (RST) begin
            a_addr  <= 5'd0;
            b_addr  <= 5'd0;
            pend_rd <= 5'd0;
        end else if (stall) begin
            pend_rd <= 5'd0; // the pending result lands in exec at this edge.
        end else begin
            if (issue_valid) begin
                a_addr <= rs1;
                b_addr <= rs2;
            end
            pend_rd <= rd_ahead;
        end
    end

    function automatic logic operand_ok(input logic [4:0] addr);
        if (addr == 5'd0) begin
            operand_ok = 1'b1;
        end else if (addr == pend_rd) begin
            operand_ok = 1'b0;
        end else begin
            operand_ok = 1'b1;
        end
    endfunction

    // the newest source wins, and the cushion stage is also the write port.
    function automatic logic [31:0] operand_data(input logic [4:0] addr);
        if (addr == 5'd0) begin
            operand_data = 32'd0;
        end else if (exec_res.valid && exec_res.rd == addr) begin
            operand_data = exec_res.data;
        end else if (cushion_res.valid && cushion_res.rd == addr) begin
            operand_data = cushion_res.data;
        end else begin
            operand_data = regs[addr];
        end
    endfunction

    assign a_rvalid = operand_ok(a_addr);
    assign b_rvalid = operand_ok(b_addr);
    assign a_rdata  = operand_data(a_addr);
    assign b_rdata  = operand_data(b_addr);

    always_ff @(posedge CLK) begin
        if (cushion_res.valid && cushion_res.rd != 5'd0) begin
            regs[cushion_res.rd] <= cushion_res.data;
        end
    end

endmodule

//--- rtl/rv32i_exec.sv
`timescale 1ns/1ps

module rv32i_exec import rv32i_pkg::*; (
    input  logic        CLK,
    input  logic        RST,
    input  logic        ex_valid,
    input  alu_op_t     ex_op,
    input  logic [31:0] ex_a,
    input  logic [31:0] ex_b,
    input  logic [4:0]  ex_rd,
    rv32i_result_if.src exec_res,
    rv32i_result_if.src cushion_res
);

    logic [31:0] alu_out;
    logic [4:0]  shamt;

    assign shamt = ex_b[4:0]; // RV32I shifts use only the low five bits.

    always_comb begin
        case (ex_op)
            ALU_ADD:  alu_out = ex_a + ex_b;
            ALU_SUB:  alu_out = ex_a - ex_b;
            ALU_SLL:  alu_out = ex_a << shamt;
            ALU_SLT:  alu_out = {31'd0, $signed(ex_a) < $signed(ex_b)};
            ALU_SLTU: alu_out = {31'd0, ex_a < ex_b};
            ALU_XOR:  alu_out = ex_a ^ ex_b;
            ALU_SRL:  alu_out = ex_a >> shamt;
            ALU_SRA:  alu_out = $unsigned($signed(ex_a) >>> shamt);
            ALU_OR:   alu_out = ex_a | ex_b;
            ALU_AND:  alu_out = ex_a & ex_b;
            ALU_PASS: alu_out = ex_b;
            default:  alu_out = 32'd0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            exec_res.valid    <= 1'b0;
            cushion_res.valid <= 1'b0;
        end else begin
            exec_res.valid    <= ex_valid;
            cushion_res.valid <= exec_res.valid;
        end
    end

    // two results can be in flight, one in each stage.
    always_ff @(posedge CLK) begin
        exec_res.rd      <= ex_rd;
        exec_res.data    <= alu_out;
        cushion_res.rd   <= exec_res.rd;
        cushion_res.data <= exec_res.data;
    end

endmodule

//--- rtl/rv32i_int_pipe.sv
`timescale 1ns/1ps

module rv32i_int_pipe import rv32i_pkg::*; (
    input  logic        CLK,
    input  logic        RST,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    output logic        wb_valid,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data
);

    inst_word_u  head;
    logic        not_empty;
    logic        pop;
    logic        issue_valid;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd_ahead;
    logic        a_rvalid;
    logic        b_rvalid;
    logic [31:0] a_rdata;
    logic [31:0] b_rdata;
    logic        stall;
    logic        ex_valid;
    alu_op_t     ex_op;
    logic [31:0] ex_a;
    logic [31:0] ex_b;
    logic [4:0]  ex_rd;

    rv32i_result_if exec_res ();
    rv32i_result_if cushion_res ();

    rv32i_inst_queue u_queue (
        .CLK       (CLK),
        .RST       (RST),
        .push      (inst_valid),
        .push_inst (inst),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty)
    );

    rv32i_issue u_issue (
        .CLK         (CLK),
        .RST         (RST),
        .head        (head),
        .not_empty   (not_empty),
        .pop         (pop),
        .issue_valid (issue_valid),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd_ahead    (rd_ahead),
        .a_rvalid    (a_rvalid),
        .b_rvalid    (b_rvalid),
        .a_rdata     (a_rdata),
        .b_rdata     (b_rdata),
        .stall       (stall),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_a        (ex_a),
        .ex_b        (ex_b),
        .ex_rd       (ex_rd)
    );

    rv32i_reg u_reg (
        .CLK         (CLK),
        .RST         (RST),
        .stall       (stall),
        .issue_valid (issue_valid),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd_ahead    (rd_ahead),
        .a_rvalid    (a_rvalid),
        .b_rvalid    (b_rvalid),
        .a_rdata     (a_rdata),
        .b_rdata     (b_rdata),
        .exec_res    (exec_res.dst),
        .cushion_res (cushion_res.dst)
    );

    rv32i_exec u_exec (
        .CLK         (CLK),
        .RST         (RST),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_a        (ex_a),
        .ex_b        (ex_b),
        .ex_rd       (ex_rd),
        .exec_res    (exec_res.src),
        .cushion_res (cushion_res.src)
    );

    assign wb_valid = cushion_res.valid;
    assign wb_rd    = cushion_res.rd;
    assign wb_data  = cushion_res.data;

endmodule

//--- testbench/tb_rv32i_int_pipe.sv
`timescale 1ns/1ps

module tb_rv32i_int_pipe import rv32i_pkg::*; ();

    logic        CLK;
    logic        RST;
    logic        inst_valid;
    logic [31:0] inst;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] model_regs [32];
    logic [4:0]  exp_rd_arr [512];
    logic [31:0] exp_data_arr [512];
    logic [4:0]  exp_rd_now;
    logic [31:0] exp_data_now;
    int          exp_count;
    int          chk_idx;
    int          wb_count;
    int          sent_count;
    int          cycle_count;
    int          error_count;
    int          tests_passed;
    int          tests_failed;
    int          errors_at_start;

    always #5 CLK = ~CLK;

    rv32i_int_pipe DUT (
        .CLK        (CLK),
        .RST        (RST),
        .inst_valid (inst_valid),
        .inst       (inst),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    assign exp_rd_now   = exp_rd_arr[chk_idx[8:0]];
    assign exp_data_now = exp_data_arr[chk_idx[8:0]];

    always @(posedge CLK) begin
        if (RST) begin
            chk_idx  <= 0;
            wb_count <= 0;
        end else begin
            if (wb_valid && chk_idx < exp_count) begin
                chk_idx <= chk_idx + 1; // the oldest expected result retires.
            end
            if (wb_valid) begin
                wb_count <= wb_count + 1;
            end
        end
    end

    always @(posedge CLK) begin
        if (RST) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
        end
        if (cycle_count > 12 * sent_count + 200) begin
            $display("timeout: pipeline made no progress after %0d cycles", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    a_wb_expected: assert property (@(posedge CLK) disable iff (RST)
        wb_valid |-> (chk_idx < exp_count))
        else begin
            error_count = error_count + 1;
            $display("write-back to x%0d arrived with no instruction left to retire",
                     $sampled(wb_rd));
        end

    a_wb_rd: assert property (@(posedge CLK) disable iff (RST)
        (wb_valid && chk_idx < exp_count) |-> (wb_rd == exp_rd_now))
        else begin
            error_count = error_count + 1;
            $display("CHECK FAILED wb_rd: got %h expected %h",
                     $sampled(wb_rd), $sampled(exp_rd_now));
        end

    a_wb_data: assert property (@(posedge CLK) disable iff (RST)
        (wb_valid && chk_idx < exp_count) |-> (wb_data == exp_data_now))
        else begin
            error_count = error_count + 1;
            $display("CHECK FAILED wb_data: got %h expected %h",
                     $sampled(wb_data), $sampled(exp_data_now));
        end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        enc_r = {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        enc_i = {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
        enc_lui = {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] random_alu(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        f3  = 3'($urandom);
        alt = 1'($urandom);
        imm = 12'($urandom);
        if (1'($urandom)) begin
            random_alu = enc_r((alt && (f3 == F3_ADD || f3 == F3_SRL)) ? 7'h20 : 7'h00,
                               rs2, rs1, f3, rd);
        end else begin
            if (f3 == F3_SLL) begin
                imm = {7'h00, imm[4:0]};
            end else if (f3 == F3_SRL) begin
                imm = {alt ? 7'h20 : 7'h00, imm[4:0]}; // SRAI or SRLI.
            end
            random_alu = enc_i(imm, rs1, f3, rd);
        end
    endfunction

    // strobes one instruction and records what RV32I says it must write back.
    task automatic send_inst(input logic [31:0] w);
        logic [6:0]  opc;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic [31:0] res;
        logic        writes;
        opc    = w[6:0];
        a      = model_regs[w[19:15]];
        b      = (opc == OPC_OP) ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        sh     = b[4:0];
        writes = (opc == OPC_OP || opc == OPC_OP_IMM || opc == OPC_LUI);
        res    = 32'd0;
        if (opc == OPC_LUI) begin
            res = {w[31:12], 12'd0};
        end else begin
            case (w[14:12])
                3'd0: res = (w[30] && opc == OPC_OP) ? a - b : a + b;
                3'd1: res = a << sh;
                3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: res = (a < b) ? 32'd1 : 32'd0;
                3'd4: res = a ^ b;
                3'd5: begin
                    if (w[30]) begin
                        res = $signed(a) >>> sh;
                    end else begin
                        res = a >> sh;
                    end
                end
                3'd6: res = a | b;
                default: res = a & b;
            endcase
        end
        @(negedge CLK);
        inst_valid = 1'b1;
        inst       = w;
        sent_count = sent_count + 1;
        if (writes) begin
            exp_rd_arr[exp_count[8:0]]   = w[11:7];
            exp_data_arr[exp_count[8:0]] = res;
            exp_count = exp_count + 1;
            if (w[11:7] != 5'd0) begin
                model_regs[w[11:7]] = res; // x0 is reported but keeps its zero.
            end
        end
        @(negedge CLK);
        inst_valid = 1'b0;
        repeat ($urandom_range(2, 0)) @(negedge CLK);
    endtask

    task automatic finish_test(input string name);
        while (chk_idx != exp_count) begin
            @(posedge CLK);
        end
        repeat (3) @(posedge CLK);
        if (error_count == errors_at_start) begin
            tests_passed = tests_passed + 1;
            $display("test %s passed, %0d write-backs so far", name, chk_idx);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s failed with %0d errors", name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    initial begin
        CLK             = 1'b0;
        RST             = 1'b1;
        inst_valid      = 1'b0;
        inst            = 32'd0;
        exp_count       = 0;
        sent_count      = 0;
        error_count     = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        errors_at_start = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = 32'd0;
        end
        void'($urandom(32'h70fcd348));
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;

        repeat (20) @(posedge CLK); // nothing issued, so any write-back is an error.
        finish_test("reset_idle");

        for (int r = 1; r < 32; r++) begin
            send_inst(enc_lui(20'($urandom), 5'(r)));
            send_inst(enc_i(12'($urandom), 5'(r), F3_ADD, 5'(r)));
        end
        finish_test("lui_fill");

        send_inst(enc_lui(20'h80000, 5'd20));
        send_inst(enc_i(12'd1, 5'd0, F3_ADD, 5'd21));
        send_inst(enc_r(7'h00, 5'd21, 5'd20, F3_SLT, 5'd22));
        send_inst(enc_r(7'h00, 5'd21, 5'd20, F3_SLTU, 5'd23));
        send_inst(enc_r(7'h20, 5'd21, 5'd20, F3_SRL, 5'd24));
        send_inst(enc_i({7'h20, 5'd31}, 5'd20, F3_SRL, 5'd25));
        send_inst(enc_i(12'd33, 5'd0, F3_ADD, 5'd26));
        send_inst(enc_r(7'h00, 5'd26, 5'd21, F3_SLL, 5'd27)); // shift by 33 acts as 1.
        send_inst(enc_i(12'hfff, 5'd0, F3_ADD, 5'd28));
        send_inst(enc_i(12'hfff, 5'd20, F3_SLTU, 5'd29));
        send_inst(enc_r(7'h20, 5'd21, 5'd0, F3_ADD, 5'd30));
        for (int k = 0; k < 60; k++) begin
            send_inst(random_alu(5'($urandom_range(31, 1)), 5'($urandom_range(31, 0)),
                                 5'($urandom_range(31, 0))));
        end
        finish_test("random_alu");

        for (int d = 1; d <= 3; d++) begin
            for (int k = 0; k < 12; k++) begin
                send_inst(random_alu(5'(5 + k % d), 5'(5 + k % d),
                                     5'($urandom_range(31, 1))));
            end
        end
        finish_test("dep_chains");

        send_inst(enc_r(7'h00, 5'd3, 5'd0, F3_OR, 5'd7));
        send_inst(enc_r(7'h20, 5'd0, 5'd4, F3_ADD, 5'd8));
        send_inst(enc_i(12'h123, 5'd5, F3_ADD, 5'd0));
        send_inst(enc_r(7'h00, 5'd0, 5'd0, F3_ADD, 5'd9));
        send_inst(enc_i(12'h7ff, 5'd0, F3_XOR, 5'd0));
        send_inst(enc_i(12'd0, 5'd0, F3_OR, 5'd10));
        send_inst(enc_lui(20'habcde, 5'd0));
        send_inst(enc_r(7'h00, 5'd0, 5'd0, F3_OR, 5'd11));
        finish_test("x0_use");

        send_inst(enc_lui(20'($urandom), 5'd12));
        send_inst(enc_i(12'd0, 5'd12, F3_ADD, 5'd13));
        send_inst({7'd0, 5'd3, 5'd4, 3'b010, 5'd12, 7'b0100011}); // store
        send_inst({7'd0, 5'd3, 5'd4, 3'b000, 5'd12, 7'b1100011}); // branch
        send_inst({20'h12345, 5'd12, 7'b1101111}); // jal
        send_inst({20'h00abc, 5'd12, 7'b0010111}); // auipc
        send_inst(enc_i(12'd0, 5'd12, F3_ADD, 5'd14));
        send_inst(enc_r(7'h00, 5'd12, 5'd13, F3_XOR, 5'd15));
        finish_test("lui_unsupported");

        repeat (30) @(negedge CLK);
        assert (wb_count == exp_count)
            else begin
                error_count = error_count + 1;
                $display("CHECK FAILED wb_count: got %h expected %h", wb_count, exp_count);
            end
        finish_test("order_count");

        $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- vlog.f
rtl/rv32i_pkg.sv
rtl/rv32i_result_if.sv
rtl/rv32i_inst_queue.sv
rtl/rv32i_issue.sv
rtl/rv32i_reg.sv
rtl/rv32i_exec.sv
rtl/rv32i_int_pipe.sv
testbench/tb_rv32i_int_pipe.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv32i_int_pipe
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
